//--- saturn_bus_params.svh
`ifndef SATURN_BUS_PARAMS_SVH
`define SATURN_BUS_PARAMS_SVH

// bus data width, one nibble per bus cycle
`define SATURN_NIBBLE_W 4

// address nibbles sent after a pointer load command
`define SATURN_ADDR_NIBBLES 5

// full nibble address
`define SATURN_ADDR_W 20

// clocks per bus cycle
`define SATURN_PHASES 4

// bus cycles with bus reset held high after core reset
`define SATURN_STARTUP_CYCLES 2

// command nibble codes
// read nibbles at the PC pointer
`define SATURN_CMD_PC_READ 0
// write nibbles at the DP pointer
`define SATURN_CMD_DP_WRITE 3
// followed by five address nibbles
`define SATURN_CMD_LOAD_PC 4
`define SATURN_CMD_LOAD_DP 5

`endif

//--- saturn_bus_pkg.sv
`include "saturn_bus_params.svh"

package saturn_bus_pkg;

  // one bus nibble
  typedef logic [`SATURN_NIBBLE_W-1:0] nibble_t;

  // nibble address as seen on the bus
  typedef logic [`SATURN_ADDR_W-1:0] addr_t;

  // transfer length minus one, 1 to 16 nibbles
  typedef logic [3:0] xfr_cnt_t;

  // position inside a bus cycle
  typedef logic [$clog2(`SATURN_PHASES)-1:0] phase_t;

  // command nibbles sent with cmd_data low
  typedef enum logic [`SATURN_NIBBLE_W-1:0] {
    CMD_PC_READ  = `SATURN_CMD_PC_READ,
    CMD_DP_WRITE = `SATURN_CMD_DP_WRITE,
    CMD_LOAD_PC  = `SATURN_CMD_LOAD_PC,
    CMD_LOAD_DP  = `SATURN_CMD_LOAD_DP
  } bus_cmd_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_t;

  // what a single bus cycle carries
  typedef enum logic [1:0] {
    SLOT_CMD   = 2'd0,
    SLOT_ADDR  = 2'd1,
    SLOT_WRITE = 2'd2,
    SLOT_READ  = 2'd3
  } slot_kind_t;

  // transfer request from the core
  typedef struct packed {
    bus_op_t  op;
    addr_t    addr;
    xfr_cnt_t cnt;
  } bus_req_t;

  // one bus cycle, nibble unused for reads
  typedef struct packed {
    slot_kind_t kind;
    nibble_t    nibble;
  } bus_slot_t;

  // pins toward the bus
  typedef struct packed {
    logic    bus_reset;
    logic    strobe;
    logic    cmd_data;
    nibble_t data;
  } bus_pins_t;

  // transfer sequencer
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    LOAD_CMD = 3'd1,
    ADDR     = 3'd2,
    XFR_CMD  = 3'd3,
    XFR      = 3'd4
  } seq_state_t;

endpackage

//--- saturn_bus_phase.sv
`include "saturn_bus_params.svh"

module saturn_bus_phase import saturn_bus_pkg::*; (
  input  logic   i_clk,
  input  logic   cmd_RESET_0,
  output phase_t o_phase,
  output logic   o_bus_up,
  output logic   o_bus_reset
);

  // last clock of a bus cycle
  localparam phase_t LAST_PHASE = phase_t'(`SATURN_PHASES - 1);

  // bus cycles spent in startup so far
  logic [1:0] startup_cnt;

  // free running, 0 on the first clock after reset
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      o_phase <= '0;
    end else begin
      o_phase <= o_phase + phase_t'(1);
    end
  end

  // startup sequencing
  // bus reset held for a fixed number of bus cycles
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      startup_cnt <= '0;
      o_bus_reset <= 1'b1;
      o_bus_up    <= 1'b0;
    end else if (o_bus_reset && (o_phase == LAST_PHASE)) begin
      if (startup_cnt == 2'(`SATURN_STARTUP_CYCLES - 1)) begin
        // release the bus at a bus cycle boundary
        o_bus_reset <= 1'b0;
        o_bus_up    <= 1'b1;
      end else begin
        startup_cnt <= startup_cnt + 2'd1;
      end
    end
  end

  // both flags flip on the same edge
  a_up_excl_reset: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    !(o_bus_up && o_bus_reset)
  );

endmodule

//--- saturn_bus_seq.sv
`include "saturn_bus_params.svh"

module saturn_bus_seq import saturn_bus_pkg::*; (
  input  logic      i_clk,
  input  logic      cmd_RESET_0,
  input  phase_t    i_phase,
  input  logic      i_bus_up,
  input  bus_req_t  i_req,
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  nibble_t   i_wr_nibble,
  input  logic      i_wr_valid,
  output logic      o_wr_ready,
  input  logic      i_rd_valid,
  output bus_slot_t o_slot,
  output logic      o_slot_valid
);

  // slots are decided on the last clock of a bus cycle
  localparam phase_t SLOT_PHASE   = phase_t'(`SATURN_PHASES - 1);
  // strobe clock, used to hold off the return to idle
  localparam phase_t STROBE_PHASE = phase_t'(1);
  localparam logic [2:0] LAST_ADDR = 3'(`SATURN_ADDR_NIBBLES - 1);

  seq_state_t state;

  // request held for the whole transfer
  bus_req_t req_q;

  // address nibble index, low nibble first
  logic [2:0] addr_idx;

  // data slots issued so far
  xfr_cnt_t xfr_idx;

  // last data slot issued, waiting for its strobe
  logic xfr_done;

  logic is_read;
  logic slot_phase;
  logic issue;
  bus_slot_t slot;

  assign is_read    = (req_q.op == OP_READ);
  assign slot_phase = (i_phase == SLOT_PHASE);

  // one request in flight, only once the bus is up
  assign o_req_ready = (state == IDLE) && i_bus_up;

  // next slot, at most one per bus cycle
  always_comb begin
    issue       = 1'b0;
    slot.kind   = SLOT_CMD;
    slot.nibble = '0;
    case (state)
      LOAD_CMD: begin
        issue       = slot_phase;
        slot.kind   = SLOT_CMD;
        slot.nibble = is_read ? nibble_t'(CMD_LOAD_PC) : nibble_t'(CMD_LOAD_DP);
      end
      ADDR: begin
        issue       = slot_phase;
        slot.kind   = SLOT_ADDR;
        slot.nibble = req_q.addr[addr_idx*`SATURN_NIBBLE_W +: `SATURN_NIBBLE_W];
      end
      XFR_CMD: begin
        issue       = slot_phase;
        slot.kind   = SLOT_CMD;
        slot.nibble = is_read ? nibble_t'(CMD_PC_READ) : nibble_t'(CMD_DP_WRITE);
      end
      XFR: begin
        if (is_read) begin
          // read register still full, skip this bus cycle
          issue     = slot_phase && !xfr_done && !i_rd_valid;
          slot.kind = SLOT_READ;
        end else begin
          // no write nibble offered, skip this bus cycle
          issue       = slot_phase && !xfr_done && i_wr_valid;
          slot.kind   = SLOT_WRITE;
          slot.nibble = i_wr_nibble;
        end
      end
      default: begin
        issue = 1'b0;
      end
    endcase
  end

  assign o_slot       = slot;
  assign o_slot_valid = issue;

  // write nibble taken in the clock its slot goes out
  assign o_wr_ready = (state == XFR) && !is_read && issue;

  // request payload
  always_ff @(posedge i_clk) begin
    if (o_req_ready && i_req_valid) begin
      req_q <= i_req;
    end
  end

  // transfer FSM
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      state    <= IDLE;
      addr_idx <= '0;
      xfr_idx  <= '0;
      xfr_done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          addr_idx <= '0;
          xfr_idx  <= '0;
          xfr_done <= 1'b0;
          if (o_req_ready && i_req_valid) begin
            state <= LOAD_CMD;
          end
        end
        LOAD_CMD: begin
          if (issue) begin
            state <= ADDR;
          end
        end
        ADDR: begin
          if (issue) begin
            addr_idx <= addr_idx + 3'd1;
            if (addr_idx == LAST_ADDR) begin
              state <= XFR_CMD;
            end
          end
        end
        XFR_CMD: begin
          if (issue) begin
            state <= XFR;
          end
        end
        XFR: begin
          if (issue) begin
            xfr_idx <= xfr_idx + xfr_cnt_t'(1);
            if (xfr_idx == req_q.cnt) begin
              xfr_done <= 1'b1;
            end
          end
          // ready only comes back once the last nibble was strobed
          if (xfr_done && (i_phase == STROBE_PHASE)) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  a_slot_in_phase3: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    o_slot_valid |-> (i_phase == SLOT_PHASE) && i_bus_up
  );

  a_wr_ready_valid: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    o_wr_ready |-> i_wr_valid
  );

endmodule

//--- saturn_bus_pins.sv
`include "saturn_bus_params.svh"

module saturn_bus_pins import saturn_bus_pkg::*; (
  input  logic      i_clk,
  input  logic      cmd_RESET_0,
  input  phase_t    i_phase,
  input  logic      i_bus_reset,
  input  bus_slot_t i_slot,
  input  logic      i_slot_valid,
  input  nibble_t   i_bus_data,
  output bus_pins_t o_bus,
  output nibble_t   o_rd_nibble,
  output logic      o_rd_valid,
  input  logic      i_rd_ready
);

  localparam phase_t LAST_PHASE = phase_t'(`SATURN_PHASES - 1);

  // a slot was latched for the current bus cycle
  logic slot_act;
  slot_kind_t kind_q;

  // registered pins
  logic    strobe_q;
  logic    cmd_data_q;
  nibble_t data_q;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      slot_act   <= 1'b0;
      kind_q     <= SLOT_CMD;
      strobe_q   <= 1'b0;
      cmd_data_q <= 1'b1;
      data_q     <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      // core takes the read nibble
      if (o_rd_valid && i_rd_ready) begin
        o_rd_valid <= 1'b0;
      end
      case (i_phase)
        LAST_PHASE: begin
          // latch slot, pins change from phase 0
          slot_act <= i_slot_valid;
          if (i_slot_valid) begin
            kind_q     <= i_slot.kind;
            data_q     <= (i_slot.kind == SLOT_READ) ? nibble_t'(0) : i_slot.nibble;
            cmd_data_q <= (i_slot.kind != SLOT_CMD);
          end
        end
        phase_t'(0): begin
          // strobe during phase 1
          strobe_q <= slot_act;
        end
        phase_t'(1): begin
          strobe_q   <= 1'b0;
          cmd_data_q <= 1'b1;
          // device data sampled at end of the strobe clock
          if (slot_act && (kind_q == SLOT_READ)) begin
            o_rd_valid <= 1'b1;
          end
        end
        default: begin
          strobe_q <= 1'b0;
        end
      endcase
    end
  end

  // read nibble, held until the core takes it
  always_ff @(posedge i_clk) begin
    if ((i_phase == phase_t'(1)) && slot_act && (kind_q == SLOT_READ)) begin
      o_rd_nibble <= i_bus_data;
    end
  end

  assign o_bus.bus_reset = i_bus_reset;
  assign o_bus.strobe    = strobe_q;
  assign o_bus.cmd_data  = cmd_data_q;
  assign o_bus.data      = data_q;

  a_strobe_phase1: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    o_bus.strobe |-> (i_phase == phase_t'(1))
  );

  // sequencer must hold read slots while the register is full
  a_no_read_overrun: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    (i_slot_valid && (i_slot.kind == SLOT_READ)) |-> !o_rd_valid
  );

endmodule

//--- saturn_bus_ctrl.sv
module saturn_bus_ctrl import saturn_bus_pkg::*; (
  input  logic      i_clk,
  input  logic      cmd_RESET_0,
  // core request channel
  input  bus_req_t  i_req,
  input  logic      i_req_valid,
  output logic      o_req_ready,
  // write stream from the core
  input  nibble_t   i_wr_nibble,
  input  logic      i_wr_valid,
  output logic      o_wr_ready,
  // read stream to the core
  output nibble_t   o_rd_nibble,
  output logic      o_rd_valid,
  input  logic      i_rd_ready,
  // bus pins
  output bus_pins_t o_bus,
  input  nibble_t   i_bus_data
);

  phase_t    phase;
  logic      bus_up;
  logic      bus_reset;
  bus_slot_t slot;
  logic      slot_valid;
  logic      rd_valid;

  // phase counter and bus startup
  saturn_bus_phase phase0 (
    .i_clk       (i_clk),
    .cmd_RESET_0 (cmd_RESET_0),
    .o_phase     (phase),
    .o_bus_up    (bus_up),
    .o_bus_reset (bus_reset)
  );

  // request sequencing, one slot per bus cycle
  saturn_bus_seq seq0 (
    .i_clk        (i_clk),
    .cmd_RESET_0  (cmd_RESET_0),
    .i_phase      (phase),
    .i_bus_up     (bus_up),
    .i_req        (i_req),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_wr_nibble  (i_wr_nibble),
    .i_wr_valid   (i_wr_valid),
    .o_wr_ready   (o_wr_ready),
    .i_rd_valid   (rd_valid),
    .o_slot       (slot),
    .o_slot_valid (slot_valid)
  );

  // pin timing and read capture
  saturn_bus_pins pins0 (
    .i_clk        (i_clk),
    .cmd_RESET_0  (cmd_RESET_0),
    .i_phase      (phase),
    .i_bus_reset  (bus_reset),
    .i_slot       (slot),
    .i_slot_valid (slot_valid),
    .i_bus_data   (i_bus_data),
    .o_bus        (o_bus),
    .o_rd_nibble  (o_rd_nibble),
    .o_rd_valid   (rd_valid),
    .i_rd_ready   (i_rd_ready)
  );

  // read valid also throttles the sequencer
  assign o_rd_valid = rd_valid;

endmodule

//--- tb_saturn_bus_device.sv
`include "saturn_bus_params.svh"

module tb_saturn_bus_device import saturn_bus_pkg::*; (
  input  logic      i_clk,
  input  bus_pins_t i_bus,
  output nibble_t   o_data,
  output logic      o_cmd_stb,
  output nibble_t   o_cmd,
  output addr_t     o_ptr
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    DEV_IDLE,
    DEV_LOAD,
    DEV_READ,
    DEV_WRITE
  } dev_mode_t;

  dev_mode_t  mode;
  logic [2:0] addr_cnt;
  addr_t      ptr;
  nibble_t    mem [256];

  // preset contents, low index nibble xor 5
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = nibble_t'(i) ^ 4'h5;
    end
  end

  // read data stays on the bus while in read mode
  assign o_data = (mode == DEV_READ) ? mem[ptr[7:0]] : '0;
  assign o_ptr  = ptr;

  // one decode per strobe
  always @(posedge i_clk) begin
    o_cmd_stb <= 1'b0;
    if (i_bus.bus_reset) begin
      mode     <= DEV_IDLE;
      addr_cnt <= '0;
      ptr      <= '0;
      o_cmd    <= '0;
    end else if (i_bus.strobe) begin
      if (!i_bus.cmd_data) begin
        // command nibble, logged for the checker
        o_cmd_stb <= 1'b1;
        o_cmd     <= i_bus.data;
        case (bus_cmd_t'(i_bus.data))
          CMD_LOAD_PC, CMD_LOAD_DP: begin
            mode     <= DEV_LOAD;
            addr_cnt <= '0;
          end
          CMD_PC_READ:  mode <= DEV_READ;
          CMD_DP_WRITE: mode <= DEV_WRITE;
          default:      mode <= DEV_IDLE;
        endcase
      end else begin
        case (mode)
          DEV_LOAD: begin
            // pointer built low nibble first
            if (addr_cnt < 3'(`SATURN_ADDR_NIBBLES)) begin
              ptr[addr_cnt*`SATURN_NIBBLE_W +: `SATURN_NIBBLE_W] <= i_bus.data;
              addr_cnt <= addr_cnt + 3'd1;
            end
          end
          DEV_READ: ptr <= ptr + addr_t'(1);
          DEV_WRITE: begin
            mem[ptr[7:0]] <= i_bus.data;
            ptr           <= ptr + addr_t'(1);
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- tb_saturn_bus.sv
`include "saturn_bus_params.svh"

module tb_saturn_bus import saturn_bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 2000;

  logic      i_clk;
  logic      cmd_RESET_0;
  bus_req_t  req;
  logic      req_valid;
  logic      req_ready;
  nibble_t   wr_nibble;
  logic      wr_valid;
  logic      wr_ready;
  nibble_t   rd_nibble;
  logic      rd_valid;
  logic      rd_ready;
  bus_pins_t bus;
  nibble_t   bus_data;
  logic      dev_cmd_stb;
  nibble_t   dev_cmd;
  addr_t     dev_ptr;

  // expected device memory, follows the writes
  nibble_t     ref_mem [256];
  logic [31:0] lfsr_q = 32'd68379;
  logic        use_gaps;
  // strobes still owed by the current transfer
  int          strobes_left;
  nibble_t     cmd_log [$];
  addr_t       ptr_log [$];

  saturn_bus_ctrl dut0 (
    .i_clk       (i_clk),
    .cmd_RESET_0 (cmd_RESET_0),
    .i_req       (req),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_wr_nibble (wr_nibble),
    .i_wr_valid  (wr_valid),
    .o_wr_ready  (wr_ready),
    .o_rd_nibble (rd_nibble),
    .o_rd_valid  (rd_valid),
    .i_rd_ready  (rd_ready),
    .o_bus       (bus),
    .i_bus_data  (bus_data)
  );

  tb_saturn_bus_device dev0 (
    .i_clk     (i_clk),
    .i_bus     (bus),
    .o_data    (bus_data),
    .o_cmd_stb (dev_cmd_stb),
    .o_cmd     (dev_cmd),
    .o_ptr     (dev_ptr)
  );

  always #2 i_clk = ~i_clk;

  task automatic fail_stop(input string msg);
    $display("TESTS FAILED");
    $display("%s", msg);
    $fatal(1);
  endtask

  function automatic string diff_text(input string name, input logic [31:0] exp,
                                      input logic [31:0] act);
    return $sformatf("mismatch %s expected %0h actual %0h", name, exp, act);
  endfunction

  // taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // transfer length and command tracking
  always @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      strobes_left <= 0;
    end else if (req_valid && req_ready) begin
      strobes_left <= 1 + `SATURN_ADDR_NIBBLES + 1 + int'(req.cnt) + 1;
    end else if (bus.strobe) begin
      strobes_left <= strobes_left - 1;
    end
    if (dev_cmd_stb) begin
      cmd_log.push_back(dev_cmd);
      ptr_log.push_back(dev_ptr);
    end
  end

  a_startup_quiet: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    bus.bus_reset |-> !req_ready && !bus.strobe)
    else fail_stop("bus was active while bus reset was high");

  // next strobe one full bus cycle later at the earliest
  a_strobe_gap: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    bus.strobe |=> !bus.strobe [*3])
    else fail_stop("two strobes closer than one bus cycle");

  a_busy_not_ready: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    (strobes_left > 0) |-> !req_ready)
    else fail_stop("request ready returned before the last nibble was strobed");

  a_strobe_owed: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    bus.strobe |-> (strobes_left > 0))
    else fail_stop("strobe outside a transfer or more strobes than the length allows");

  a_rd_hold: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_nibble))
    else fail_stop("read nibble changed or dropped before it was taken");

  task automatic check_startup();
    int idle;
    idle = 0;
    @(posedge i_clk);
    assert (bus.bus_reset) else fail_stop(diff_text("startup bus_reset", 1, bus.bus_reset));
    do begin
      @(posedge i_clk);
      idle++;
      assert (idle < WAIT_LIMIT) else fail_stop("bus never came up after reset");
    end while (!req_ready);
    assert (!bus.bus_reset) else fail_stop(diff_text("startup bus_reset", 0, bus.bus_reset));
  endtask

  task automatic send_request(input bus_req_t r);
    int idle;
    idle = 0;
    @(posedge i_clk);
    req       <= r;
    req_valid <= 1'b1;
    do begin
      @(posedge i_clk);
      idle++;
      assert (idle < WAIT_LIMIT) else fail_stop("request was never accepted");
    end while (!req_ready);
    req_valid <= 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int idle;
    idle = 0;
    do begin
      @(posedge i_clk);
      idle++;
      assert (idle < WAIT_LIMIT) else fail_stop("transfer never finished");
    end while (!req_ready);
    // nothing beyond the requested length
    assert (!rd_valid) else fail_stop(diff_text({name, " extra rd_valid"}, 0, rd_valid));
  endtask

  task automatic collect_reads(input string name, input addr_t addr, input int n);
    int got;
    int idle;
    logic [7:0] idx;
    got  = 0;
    idle = 0;
    while (got < n) begin
      @(posedge i_clk);
      if (rd_valid && rd_ready) begin
        idx = addr[7:0] + 8'(got);
        assert (rd_nibble == ref_mem[idx])
          else fail_stop(diff_text(name, ref_mem[idx], rd_nibble));
        got++;
        idle = 0;
      end else begin
        idle++;
        assert (idle < WAIT_LIMIT) else fail_stop("read stream stopped delivering nibbles");
      end
      rd_ready <= use_gaps ? rand_bits(1) : 1'b1;
    end
    rd_ready <= 1'b0;
  endtask

  task automatic feed_writes(input addr_t addr, input int n);
    int sent;
    int idle;
    int gap;
    logic [7:0] idx;
    sent = 0;
    idle = 0;
    gap  = 0;
    while (sent < n) begin
      @(posedge i_clk);
      if (wr_valid && wr_ready) begin
        idx          = addr[7:0] + 8'(sent);
        ref_mem[idx] = wr_nibble;
        sent++;
        idle = 0;
        // random pause before the next nibble
        gap = use_gaps ? int'(rand_bits(3)) : 0;
        wr_valid <= 1'b0;
      end else if (!wr_valid) begin
        if (gap > 0) begin
          gap--;
        end else begin
          wr_nibble <= nibble_t'(rand_bits(4));
          wr_valid  <= 1'b1;
        end
      end
      idle++;
      assert (idle < WAIT_LIMIT) else fail_stop("write stream was never drained");
    end
  endtask

  // order, count and pointer of the command nibbles
  task automatic check_commands(input string name, input nibble_t load_cmd,
                                input nibble_t xfr_cmd, input addr_t addr);
    assert (cmd_log.size() == 2)
      else fail_stop(diff_text({name, " command count"}, 2, cmd_log.size()));
    assert (cmd_log[0] == load_cmd)
      else fail_stop(diff_text({name, " load command"}, load_cmd, cmd_log[0]));
    assert (cmd_log[1] == xfr_cmd)
      else fail_stop(diff_text({name, " transfer command"}, xfr_cmd, cmd_log[1]));
    assert (ptr_log[1] == addr)
      else fail_stop(diff_text({name, " address"}, addr, ptr_log[1]));
    cmd_log.delete();
    ptr_log.delete();
  endtask

  task automatic run_read(input string name, input addr_t addr, input xfr_cnt_t cnt);
    send_request('{op: OP_READ, addr: addr, cnt: cnt});
    collect_reads(name, addr, int'(cnt) + 1);
    wait_idle(name);
    check_commands(name, nibble_t'(`SATURN_CMD_LOAD_PC), nibble_t'(`SATURN_CMD_PC_READ), addr);
  endtask

  task automatic run_write(input string name, input addr_t addr, input xfr_cnt_t cnt);
    send_request('{op: OP_WRITE, addr: addr, cnt: cnt});
    feed_writes(addr, int'(cnt) + 1);
    wait_idle(name);
    check_commands(name, nibble_t'(`SATURN_CMD_LOAD_DP), nibble_t'(`SATURN_CMD_DP_WRITE), addr);
  endtask

  initial begin
    addr_t    a;
    xfr_cnt_t c;
    i_clk       = 1'b0;
    cmd_RESET_0 = 1'b1;
    req         = '0;
    req_valid   = 1'b0;
    wr_nibble   = '0;
    wr_valid    = 1'b0;
    rd_ready    = 1'b0;
    use_gaps    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = nibble_t'(i) ^ 4'h5;
    end
    repeat (10) @(posedge i_clk);
    cmd_RESET_0 <= 1'b0;
    check_startup();
    // longest read against the preset rule
    run_read("read_rule", addr_t'(rand_bits(20)), 4'hf);
    a = addr_t'(rand_bits(20));
    c = xfr_cnt_t'(rand_bits(4));
    run_write("write_fill", a, c);
    run_read("read_back", a, c);
    // same again with stalls on both streams
    use_gaps = 1'b1;
    for (int k = 0; k < 6; k++) begin
      a = addr_t'(rand_bits(20));
      c = xfr_cnt_t'(rand_bits(4));
      run_write("gap_write", a, c);
      run_read("gap_read", a, c);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
saturn_bus_pkg.sv
saturn_bus_phase.sv
saturn_bus_seq.sv
saturn_bus_pins.sv
saturn_bus_ctrl.sv
tb_saturn_bus_device.sv
tb_saturn_bus.sv
